// File: bench/femtoCoreTb.sv
// Program, data and all addresses fit a 4 KB memory model that wraps above 0xFFF; busy is random
`timescale 1ns/1ps

module femtoCoreTb
   import rvIsaPkg::*;
   import corePkg::*;
();

   localparam int cycleLimit = 200000;  // Stall limit for the whole program
   localparam int codeWords  = 380;     // Random body stops near here

   typedef struct packed {
      word_t  addr;
      word_t  data;
      wmask_t mask;
   } storeEv_t;

   logic     clk;
   logic     mem_rstrb;
   word_t    memRdata;
   logic     memRbusy;
   logic     memWbusy;
   word_t    memAddr;
   word_t    memWdata;
   wmask_t   memWmask;
   logic     memRead;
   word_t    mem [0:1023];              // Memory seen by the DUT
   word_t    refMem [0:1023];           // Model copy
   word_t    expReads [$];              // Fetch and load addresses in order
   storeEv_t expStores [$];
   word_t    endPc;                     // Final jump to self
   int       emitPtr;                   // Next code word
   int       endFetches;
   logic     fetchSeen;
   int       fetchErrors, storeErrors, maskErrors, otherErrors;

   femtoCore i_femtoCore (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .memAddr   (memAddr),
      .memWdata  (memWdata),
      .memWmask  (memWmask),
      .memRead   (memRead)
   );

   always #50 clk = ~clk;               // 100 ns period

   task automatic checkFetch(word_t expAddr);
      if (memAddr !== expAddr) begin
         fetchErrors++;
         $display("MISMATCH at %0t: memAddr %h, expected %h", $time, memAddr, expAddr);
      end
   endtask

   task automatic checkMask(wmask_t expMask);
      if (memWmask !== expMask) begin
         maskErrors++;
         $display("MISMATCH at %0t: memWmask %b, expected %b", $time, memWmask, expMask);
      end
   endtask

   task automatic checkStore(word_t expAddr, word_t expData, wmask_t expMask);
      word_t lanes;
      lanes = {{8{expMask[3]}}, {8{expMask[2]}}, {8{expMask[1]}}, {8{expMask[0]}}};
      if (memAddr !== expAddr) begin
         storeErrors++;
         $display("MISMATCH at %0t: store memAddr %h, expected %h", $time, memAddr, expAddr);
      end
      if (memWmask !== expMask) begin
         storeErrors++;
         $display("MISMATCH at %0t: store memWmask %b, expected %b", $time, memWmask, expMask);
      end
      if ((memWdata & lanes) !== (expData & lanes)) begin   // Disabled lanes are don't care
         storeErrors++;
         $display("MISMATCH at %0t: memWdata %h, expected %h", $time, memWdata & lanes,
                  expData & lanes);
      end
   endtask

   // Instruction encoders
   function automatic word_t encR(logic [6:0] f7, regId_t rs2, regId_t rs1, logic [2:0] f3,
                                  regId_t rd);
      return {f7, rs2, rs1, f3, rd, opAluReg, 2'b11};
   endfunction

   function automatic word_t encI(logic [11:0] imm, regId_t rs1, logic [2:0] f3, regId_t rd,
                                  opcode_t op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic word_t encS(logic [11:0] imm, regId_t rs2, regId_t rs1, logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic word_t encB(logic [12:0] imm, regId_t rs2, regId_t rs1, logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic word_t encU(logic [19:0] imm, regId_t rd, opcode_t op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic word_t encJ(logic [20:0] imm, regId_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   function automatic int randBelow(int n);
      return int'($urandom % n);
   endfunction

   function automatic regId_t randDest();
      return regId_t'(randBelow(31));   // x0..x30, x31 is the data base
   endfunction

   function automatic regId_t randSrc();
      return regId_t'(randBelow(32));
   endfunction

   task automatic emit(word_t w);
      mem[emitPtr] = w;
      emitPtr++;
   endtask

   // One random register or immediate ALU op, shifts included
   task automatic emitAluOp();
      logic [2:0] f3;
      logic       alt;
      f3  = 3'(randBelow(8));
      alt = (f3 == f3Add || f3 == f3Srx) && (randBelow(2) == 1);   // SUB or SRA
      if (randBelow(2) == 1) begin
         emit(encR(alt ? 7'h20 : 7'h00, randSrc(), randSrc(), f3, randDest()));
      end else if (f3 == f3Sll || f3 == f3Srx) begin
         emit(encI({alt ? 7'h20 : 7'h00, 5'(randBelow(32))}, randSrc(), f3, randDest(),
                   opAluImm));
      end else begin
         emit(encI(12'($urandom), randSrc(), f3, randDest(), opAluImm));
      end
   endtask

   task automatic emitFiller(int n);
      repeat (n) emitAluOp();            // Skipped or executed, per branch outcome
   endtask

   task automatic buildProgram();
      int         i;
      int         kind;
      int         k;
      int         off;
      int         idx;
      regId_t     tmp;
      logic [2:0] f3;
      for (i = 0; i < 1024; i++) begin
         mem[i] = word_t'(i) * 32'h9E37_79B1 + 32'h7F4A_7C15;   // Hash of the word index
      end
      emitPtr = 0;
      for (i = 1; i < 31; i++) begin
         emit(encU(20'($urandom), regId_t'(i), opLui));
         emit(encI(12'($urandom), regId_t'(i), f3Add, regId_t'(i), opAluImm));
      end
      emit(encU(20'h1, 5'd31, opLui));
      emit(encI(12'hE00, 5'd31, f3Add, 5'd31, opAluImm));     // x31 = 0xE00
      while (emitPtr < codeWords) begin
         kind = randBelow(100);
         k    = 1 + randBelow(3);
         if (kind < 40) begin
            emitAluOp();
         end else if (kind < 45) begin
            emit(encU(20'($urandom), randDest(), opLui));
         end else if (kind < 50) begin
            emit(encU(20'(randBelow(256)), randDest(), opAuipc));  // Small, no 24-bit wrap
         end else if (kind < 65) begin
            idx = randBelow(5);
            f3  = 3'(idx < 3 ? idx : idx + 1);                 // LB LH LW LBU LHU
            off = (randBelow(512) - 256) & ~((1 << f3[1:0]) - 1);
            emit(encI(12'(off), 5'd31, f3, regId_t'(1 + randBelow(30)), opLoad));
         end else if (kind < 80) begin
            f3  = 3'(randBelow(3));
            off = (randBelow(512) - 256) & ~((1 << f3[1:0]) - 1);
            emit(encS(12'(off), randSrc(), 5'd31, f3));
         end else if (kind < 90) begin
            idx = randBelow(6);
            f3  = 3'(idx < 2 ? idx : idx + 2);
            tmp = randSrc();
            emit(encB(13'(4 * (k + 1)), (randBelow(4) == 0) ? tmp : randSrc(), tmp, f3));
            emitFiller(k);
         end else if (kind < 95) begin
            emit(encJ(21'(4 * (k + 1)), randDest()));
            emitFiller(k);
         end else begin
            tmp = regId_t'(1 + randBelow(30));
            emit(encU(20'h0, tmp, opAuipc));
            // Odd offset half the time, bit 0 of the target must drop
            emit(encI(12'(8 + 4 * k + randBelow(2)), tmp, f3Add, randDest(), opJalr));
            emitFiller(k);
         end
      end
      for (i = 0; i < 32; i++) begin
         emit(encS(12'(4 * i - 256), regId_t'(i), 5'd31, f3Word));   // Register dump
      end
      endPc = word_t'(emitPtr * 4);
      emit(encJ(21'd0, 5'd0));
      refMem = mem;
   endtask

   function automatic word_t aluResult(logic [2:0] f3, logic alt, word_t a, word_t b);
      shamt_t sh;
      sh = b[4:0];
      case (f3)
         f3Add:   return alt ? a - b : a + b;
         f3Sll:   return a << sh;
         f3Slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         f3Sltu:  return (a < b) ? 32'd1 : 32'd0;
         f3Xor:   return a ^ b;
         f3Srx:   return alt ? word_t'($signed(a) >>> sh) : a >> sh;
         f3Or:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
      case (f3)
         f3Beq:   return a == b;
         f3Bne:   return a != b;
         f3Blt:   return $signed(a) < $signed(b);
         f3Bge:   return $signed(a) >= $signed(b);
         f3Bltu:  return a < b;
         f3Bgeu:  return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   function automatic word_t loadValue(word_t w, logic [2:0] f3, logic [1:0] off);
      word_t sh;
      sh = w >> (8 * off);
      case (f3[1:0])
         2'b00:   return f3[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
         2'b01:   return f3[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
         default: return w;
      endcase
   endfunction

   // ISA model, fills the expected read and store streams
   task automatic runModel();
      word_t      x [0:31];
      word_t      pc, ins, a, b, iImm, sImm, bImm, jImm, res, addr, next;
      opcode_t    op;
      logic [2:0] f3;
      logic       wr, done;
      int         steps, i;
      storeEv_t   ev;
      for (i = 0; i < 32; i++) begin
         x[i] = '0;
      end
      pc    = word_t'(resetAddr);
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 5000) begin
         ins  = refMem[pc[11:2]];
         op   = opcode_t'(ins[6:2]);
         f3   = ins[14:12];
         a    = x[ins[19:15]];
         b    = x[ins[24:20]];
         iImm = {{20{ins[31]}}, ins[31:20]};
         sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         jImm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         next = pc + 32'd4;
         res  = '0;
         wr   = 1'b1;
         expReads.push_back(pc);
         case (op)
            opLui:   res = {ins[31:12], 12'b0};
            opAuipc: res = pc + {ins[31:12], 12'b0};
            opJal: begin
               res  = pc + 32'd4;
               next = pc + jImm;
               done = (jImm == '0);      // Jump to self ends the program
            end
            opJalr: begin
               res  = pc + 32'd4;
               next = (a + iImm) & ~32'd1;
            end
            opBranch: begin
               wr = 1'b0;
               if (branchTaken(f3, a, b)) begin
                  next = pc + bImm;
               end
            end
            opLoad: begin
               addr = a + iImm;
               expReads.push_back(addr);
               res = loadValue(refMem[addr[11:2]], f3, addr[1:0]);
            end
            opStore: begin
               wr      = 1'b0;
               addr    = a + sImm;
               ev.addr = addr;
               case (f3[1:0])
                  2'b00:   ev.data = {4{b[7:0]}};
                  2'b01:   ev.data = {2{b[15:0]}};
                  default: ev.data = b;
               endcase
               ev.mask = (f3[1:0] == 2'b00) ? wmask_t'(4'b0001 << addr[1:0]) :
                         (f3[1:0] == 2'b01) ? wmask_t'(4'b0011 << addr[1:0]) : 4'b1111;
               expStores.push_back(ev);
               for (i = 0; i < 4; i++) begin
                  if (ev.mask[i]) begin
                     refMem[addr[11:2]][8*i +: 8] = ev.data[8*i +: 8];
                  end
               end
            end
            default: begin                // ALU, SUB only on register ops
               res = aluResult(f3, ins[30] && (op == opAluReg || f3 == f3Srx), a,
                               (op == opAluReg) ? b : iImm);
            end
         endcase
         if (wr && ins[11:7] != 5'd0) begin
            x[ins[11:7]] = res;
         end
         pc = next;
         steps++;
      end
      if (!done) begin
         otherErrors++;
         $display("Reference model never reached the final jump to self");
      end
   endtask

   // Bus monitor and memory model, mid-cycle while DUT outputs are settled
   always @(negedge clk) begin
      storeEv_t ev;
      int       b;
      if (!fetchSeen) begin
         checkMask('0);                  // Quiet bus until the first fetch
      end
      if (memWmask != '0) begin
         if (expStores.size() == 0) begin
            otherErrors++;
            $display("Store at %0t to %h that the program never issues", $time, memAddr);
         end else begin
            ev = expStores.pop_front();
            checkStore(ev.addr, ev.data, ev.mask);
         end
         for (b = 0; b < 4; b++) begin
            if (memWmask[b]) begin
               mem[memAddr[11:2]][8*b +: 8] = memWdata[8*b +: 8];
            end
         end
      end
      if (memRead) begin
         fetchSeen = 1'b1;
         checkMask('0);
         if (expReads.size() != 0) begin
            checkFetch(expReads.pop_front());
         end else begin
            checkFetch(endPc);           // Parked in the final loop
            endFetches++;
         end
         memRdata = mem[memAddr[11:2]];  // Held until the next read
      end
      memRbusy = ($urandom % 3) == 0;
      memWbusy = ($urandom % 4) == 0;
   end

   initial begin
      int cycles;
      clk         = 1'b0;
      mem_rstrb   = 1'b1;
      memRdata    = '0;
      memRbusy    = 1'b0;
      memWbusy    = 1'b0;
      fetchSeen   = 1'b0;
      endFetches  = 0;
      fetchErrors = 0;
      storeErrors = 0;
      maskErrors  = 0;
      otherErrors = 0;
      void'($urandom(30338));
      buildProgram();
      runModel();
      repeat (8) @(posedge clk);
      @(negedge clk);
      mem_rstrb = 1'b0;
      cycles    = 0;
      while ((expReads.size() != 0 || expStores.size() != 0 || endFetches < 2) &&
             cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      if (expReads.size() != 0 || expStores.size() != 0 || endFetches < 2) begin
         otherErrors++;
         $display("Core stalled: %0d reads and %0d stores still outstanding after %0d cycles",
                  expReads.size(), expStores.size(), cycles);
      end
      $display("Errors: fetch %0d, store %0d, mask %0d, other %0d",
               fetchErrors, storeErrors, maskErrors, otherErrors);
      if (fetchErrors + storeErrors + maskErrors + otherErrors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal -f src.f --top-module femtoCoreTb -o femtoCoreSim
./obj_dir/femtoCoreSim > sim.log
cat sim.log
if grep -qx "ALL CHECKS PASSED" sim.log; then
   exit 0
fi
exit 1

// File: source/coreIfs.sv
// Internal core buses only; no clock in the interfaces, every signal is sampled on the core clk
`timescale 1ns/1ps

// Sequencer <-> execute unit
interface seqIf
   import rvIsaPkg::*;
   import corePkg::*;
   ();

   instr_t instr;                   // Latched instruction
   addr_t  pc;                      // Address of the current instruction
   logic   execStrobe;              // High in stExecute
   logic   waitStrobe;              // High in stWaitAluMem
   addr_t  nextPc;                  // pc of the following instruction
   addr_t  dataAddr;                // Load/store address
   logic   loadRead;                // Load asks for a memory read
   logic   needWait;                // Instruction needs stWaitAluMem
   logic   aluBusy;                 // Serial shifter still running

   modport seq (
      output instr, pc, execStrobe, waitStrobe,
      input  nextPc, dataAddr, loadRead, needWait, aluBusy
   );

   modport exec (
      input  instr, pc, execStrobe, waitStrobe,
      output nextPc, dataAddr, loadRead, needWait, aluBusy
   );

endinterface

// Register file read and write ports
interface regIf
   import rvIsaPkg::*;
   ();

   regId_t rs1Id;                   // Read indices, straight from memRdata
   regId_t rs2Id;
   logic   readEn;                  // Capture operands
   word_t  rs1;                     // Registered operands
   word_t  rs2;
   logic   writeEn;
   regId_t rdId;
   word_t  writeData;

   modport seq (
      output rs1Id, rs2Id, readEn
   );

   modport store (
      input  rs1Id, rs2Id, readEn, writeEn, rdId, writeData,
      output rs1, rs2
   );

   modport exec (
      input  rs1, rs2,
      output writeEn, rdId, writeData
   );

endinterface

// File: source/corePkg.sv
// Core organisation; addresses above addrWidth bits wrap and read back as zero on memAddr
package corePkg;

   // Internal address arithmetic is narrower than a word
   localparam int addrWidth = 24;

   typedef logic [addrWidth-1:0] addr_t;

   // First fetch address after reset
   localparam addr_t resetAddr = '0;

   // Multi-cycle sequencer states
   typedef enum logic [1:0] {
      stFetch,                      // Pulse memRead at pc
      stWaitInstr,                  // Hold until instruction word arrives
      stExecute,                    // One cycle, pc update
      stWaitAluMem                  // Shifter, load or store in flight
   } seqState_t;

endpackage

// File: source/executeUnit.sv
// Decode, ALU and load/store lanes; shifts run one bit per cycle, misaligned accesses are not trapped
`timescale 1ns/1ps

module executeUnit
   import rvIsaPkg::*;
   import corePkg::*;
(
   input  logic   clk,
   input  logic   mem_rstrb,
   input  word_t  memRdata,
   output word_t  memWdata,
   output wmask_t memWmask,
   seqIf.exec     seq,
   regIf.exec     regs
);

   instr_t  instr;
   opcode_t opcode;
   logic [2:0] funct3;
   logic    isLoad, isAluImm, isStore, isAluReg, isJal, isJalr, isLui, isAuipc, isBranch;
   logic    isAlu, isShift;
   word_t   uImm, iImm, sImm, bImm, jImm;
   word_t   aluIn1, aluIn2, aluPlus, aluOut;
   logic [32:0] aluMinus;           // Bit 32 is the borrow
   logic    lt, ltu, eq, predicate;
   word_t   shiftReg;
   shamt_t  shiftCnt;
   addr_t   pcPlus4, pcPlusImm, jalrTarget;
   logic    byteAccess, halfAccess, wordAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic    loadSign;
   word_t   loadData;
   wmask_t  storeMask;

   assign instr  = seq.instr;
   assign opcode = opcode_t'(instr[6:2]);
   assign funct3 = instr[14:12];

   assign isLoad   = (opcode == opLoad);
   assign isAluImm = (opcode == opAluImm);
   assign isStore  = (opcode == opStore);
   assign isAluReg = (opcode == opAluReg);
   assign isJal    = (opcode == opJal);
   assign isJalr   = (opcode == opJalr);
   assign isLui    = (opcode == opLui);
   assign isAuipc  = (opcode == opAuipc);
   assign isBranch = (opcode == opBranch);
   assign isAlu    = isAluImm | isAluReg;
   assign isShift  = isAlu & ((funct3 == f3Sll) | (funct3 == f3Srx));

   // Immediate formats
   assign uImm = {instr[31:12], 12'b0};
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   assign aluIn1  = regs.rs1;
   assign aluIn2  = (isAluReg | isBranch) ? regs.rs2 : iImm;
   assign aluPlus = aluIn1 + aluIn2; // Also the JALR target

   // One subtraction feeds SUB and every comparison
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;
   assign ltu = aluMinus[32];
   assign lt  = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];
   assign eq  = (aluMinus[31:0] == '0);

   always_comb begin
      case (funct3)
         f3Add:   aluOut = (instr[30] & instr[5]) ? aluMinus[31:0] : aluPlus; // SUB only on reg ops
         f3Slt:   aluOut = {31'b0, lt};
         f3Sltu:  aluOut = {31'b0, ltu};
         f3Xor:   aluOut = aluIn1 ^ aluIn2;
         f3Or:    aluOut = aluIn1 | aluIn2;
         f3And:   aluOut = aluIn1 & aluIn2;
         default: aluOut = shiftReg;  // SLL, SRL, SRA
      endcase
   end

   always_comb begin
      case (funct3)
         f3Beq:   predicate = eq;
         f3Bne:   predicate = !eq;
         f3Blt:   predicate = lt;
         f3Bge:   predicate = !lt;
         f3Bltu:  predicate = ltu;
         f3Bgeu:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

   // Serial shifter, counter loaded in execute
   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         shiftCnt <= '0;
      end else if (seq.execStrobe & isShift) begin
         shiftCnt <= shamt_t'(aluIn2[4:0]);
      end else if (|shiftCnt) begin
         shiftCnt <= shiftCnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (seq.execStrobe & isShift) begin
         shiftReg <= aluIn1;
      end else if (|shiftCnt) begin
         // SLL left, SRA keeps sign, SRL fills zero
         shiftReg <= (funct3 == f3Sll) ? {shiftReg[30:0], 1'b0} :
                     {instr[30] & shiftReg[31], shiftReg[31:1]};
      end
   end

   assign seq.aluBusy = |shiftCnt;

   // Next pc
   assign pcPlus4    = seq.pc + addr_t'(4);
   assign pcPlusImm  = seq.pc + (isJal ? addr_t'(jImm) : isAuipc ? addr_t'(uImm) : addr_t'(bImm));
   assign jalrTarget = {aluPlus[addrWidth-1:1], 1'b0};   // Bit 0 cleared
   assign seq.nextPc = isJalr ? jalrTarget :
                       (isJal | (isBranch & predicate)) ? pcPlusImm : pcPlus4;

   // Load/store address, sImm only for stores
   assign seq.dataAddr = addr_t'(regs.rs1) + (isStore ? addr_t'(sImm) : addr_t'(iImm));
   assign seq.loadRead = seq.execStrobe & isLoad;
   assign seq.needWait = isLoad | isStore | isShift;

   assign byteAccess = (funct3[1:0] == f3Byte[1:0]);
   assign halfAccess = (funct3[1:0] == f3Half[1:0]);
   assign wordAccess = (funct3[1:0] == f3Word[1:0]);

   // Load lane select
   assign loadHalf = seq.dataAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = seq.dataAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]); // LBU, LHU zero fill
   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} : memRdata;

   // Store lanes, low bytes copied upward
   assign memWdata[7:0]   = regs.rs2[7:0];
   assign memWdata[15:8]  = seq.dataAddr[0] ? regs.rs2[7:0] : regs.rs2[15:8];
   assign memWdata[23:16] = seq.dataAddr[1] ? regs.rs2[7:0] : regs.rs2[23:16];
   assign memWdata[31:24] = seq.dataAddr[0] ? regs.rs2[7:0] :
                            seq.dataAddr[1] ? regs.rs2[15:8] : regs.rs2[31:24];

   always_comb begin
      if (wordAccess) begin
         storeMask = 4'b1111;
      end else if (halfAccess) begin
         storeMask = seq.dataAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = wmask_t'(4'b0001 << seq.dataAddr[1:0]);  // One byte lane
      end
   end

   assign memWmask = {4{seq.execStrobe & isStore}} & storeMask; // Single-cycle store

   // Write-back, repeated in wait so the last value wins
   assign regs.rdId    = instr[11:7];
   assign regs.writeEn = !(isBranch | isStore) & (seq.execStrobe | seq.waitStrobe);

   always_comb begin
      if (isLui) begin
         regs.writeData = uImm;
      end else if (isAuipc) begin
         regs.writeData = word_t'(pcPlusImm);
      end else if (isJal | isJalr) begin
         regs.writeData = word_t'(pcPlus4);    // Link address
      end else if (isLoad) begin
         regs.writeData = loadData;
      end else begin
         regs.writeData = aluOut;
      end
   end

endmodule

// File: source/femtoCore.sv
// RV32I core top; one shared bus for instructions and data, memAddr upper byte always zero
`timescale 1ns/1ps

module femtoCore
   import rvIsaPkg::*;
(
   input  logic   clk,
   input  logic   mem_rstrb,        // Synchronous reset, active high
   input  word_t  memRdata,
   input  logic   memRbusy,
   input  logic   memWbusy,
   output word_t  memAddr,
   output word_t  memWdata,
   output wmask_t memWmask,
   output logic   memRead           // Read request pulse
);

   seqIf seqBus ();                 // Sequencer <-> execute
   regIf regBus ();                 // Operand and write-back traffic

   // FSM, pc and instruction register
   instrSequencer i_instrSequencer (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .memAddr   (memAddr),
      .memRead   (memRead),
      .seq       (seqBus.seq),
      .regs      (regBus.seq)
   );

   registerFile i_registerFile (
      .clk  (clk),
      .regs (regBus.store)
   );

   // ALU, branches and load/store lanes
   executeUnit i_executeUnit (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .memRdata  (memRdata),
      .memWdata  (memWdata),
      .memWmask  (memWmask),
      .seq       (seqBus.exec),
      .regs      (regBus.exec)
   );

endmodule

// File: source/instrSequencer.sv
// FSM and pc; memory must hold memRdata until memRbusy drops, no request handshake exists
`timescale 1ns/1ps

module instrSequencer
   import rvIsaPkg::*;
   import corePkg::*;
(
   input  logic  clk,
   input  logic  mem_rstrb,
   input  word_t memRdata,
   input  logic  memRbusy,
   input  logic  memWbusy,
   output word_t memAddr,
   output logic  memRead,
   seqIf.seq     seq,
   regIf.seq     regs
);

   seqState_t state;
   addr_t     pc;                   // Program counter
   instr_t    instrReg;             // Instruction register, bits 1:0 dropped
   logic      fetching;             // Address bus carries pc
   logic      instrArrived;

   // Word arrives in stWaitInstr once the memory stops stalling
   assign instrArrived = (state == stWaitInstr) && !memRbusy;

   // Operand read overlaps the instruction latch
   assign regs.rs1Id  = memRdata[19:15];
   assign regs.rs2Id  = memRdata[24:20];
   assign regs.readEn = instrArrived;

   // Strobes towards the execute unit
   assign seq.instr      = instrReg;
   assign seq.pc         = pc;
   assign seq.execStrobe = (state == stExecute);
   assign seq.waitStrobe = (state == stWaitAluMem);

   // pc stays on the bus while the instruction word is pending
   assign fetching = (state == stFetch) || (state == stWaitInstr);
   assign memAddr  = word_t'(fetching ? pc : seq.dataAddr);   // Zero extension

   // Instruction fetch or load data request
   assign memRead = (state == stFetch) || seq.loadRead;

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= stWaitAluMem;     // Wait for idle memory before first fetch
         pc    <= resetAddr;
      end else begin
         case (state)
            stFetch: begin
               state <= stWaitInstr;
            end
            stWaitInstr: begin
               if (instrArrived) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               pc    <= seq.nextPc; // Branch, jump or pc + 4
               state <= seq.needWait ? stWaitAluMem : stFetch;
            end
            stWaitAluMem: begin
               // Shifter done and memory idle
               if (!seq.aluBusy && !memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
            default: begin
               state <= stWaitAluMem;
            end
         endcase
      end
   end

   // Instruction latch, no reset needed
   always_ff @(posedge clk) begin
      if (instrArrived) begin
         instrReg <= memRdata[31:2];
      end
   end

endmodule

// File: source/registerFile.sv
// 31 storage registers, x0 reads as zero; operands are registered so they lag readEn by a cycle
`timescale 1ns/1ps

module registerFile
   import rvIsaPkg::*;
(
   input  logic clk,
   regIf.store  regs
);

   word_t bank [1:31];              // x1..x31, x0 has no storage
   word_t rs1Reg;
   word_t rs2Reg;

   assign regs.rs1 = rs1Reg;
   assign regs.rs2 = rs2Reg;

   always_ff @(posedge clk) begin
      // Operand capture, held until the next instruction
      if (regs.readEn) begin
         rs1Reg <= (regs.rs1Id == '0) ? '0 : bank[regs.rs1Id];
         rs2Reg <= (regs.rs2Id == '0) ? '0 : bank[regs.rs2Id];
      end
      // Writes to x0 are dropped
      if (regs.writeEn && (regs.rdId != '0)) begin
         bank[regs.rdId] <= regs.writeData;
      end
   end

endmodule

// File: source/rvIsaPkg.sv
// RV32I encoding only; bits 1:0 of an instruction are assumed 2'b11 and never checked
package rvIsaPkg;

   // Data path widths with a meaning of their own
   typedef logic [31:0] word_t;     // Register and memory word
   typedef logic [4:0]  regId_t;    // Register index x0..x31
   typedef logic [31:2] instr_t;    // Latched instruction, low two bits dropped
   typedef logic [4:0]  shamt_t;    // Shift amount
   typedef logic [3:0]  wmask_t;    // One bit per byte lane

   // Major opcodes, taken from instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,          // rd <- mem[rs1 + Iimm]
      opAluImm = 5'b00100,          // rd <- rs1 OP Iimm
      opAuipc  = 5'b00101,          // rd <- pc + Uimm
      opStore  = 5'b01000,          // mem[rs1 + Simm] <- rs2
      opAluReg = 5'b01100,          // rd <- rs1 OP rs2
      opLui    = 5'b01101,          // rd <- Uimm
      opBranch = 5'b11000,          // if (rs1 OP rs2) pc <- pc + Bimm
      opJalr   = 5'b11001,          // rd <- pc + 4, pc <- rs1 + Iimm
      opJal    = 5'b11011           // rd <- pc + 4, pc <- pc + Jimm
   } opcode_t;

   // ALU funct3 codes
   localparam logic [2:0] f3Add  = 3'b000;   // ADD, SUB when bit 30 set on reg ops
   localparam logic [2:0] f3Sll  = 3'b001;
   localparam logic [2:0] f3Slt  = 3'b010;
   localparam logic [2:0] f3Sltu = 3'b011;
   localparam logic [2:0] f3Xor  = 3'b100;
   localparam logic [2:0] f3Srx  = 3'b101;   // SRL, or SRA when bit 30 set
   localparam logic [2:0] f3Or   = 3'b110;
   localparam logic [2:0] f3And  = 3'b111;

   // Branch funct3 codes
   localparam logic [2:0] f3Beq  = 3'b000;
   localparam logic [2:0] f3Bne  = 3'b001;
   localparam logic [2:0] f3Blt  = 3'b100;
   localparam logic [2:0] f3Bge  = 3'b101;
   localparam logic [2:0] f3Bltu = 3'b110;
   localparam logic [2:0] f3Bgeu = 3'b111;

   // Load/store access size in funct3[1:0], funct3[2] marks unsigned loads
   localparam logic [2:0] f3Byte = 3'b000;
   localparam logic [2:0] f3Half = 3'b001;
   localparam logic [2:0] f3Word = 3'b010;

endpackage

// File: src.f
source/rvIsaPkg.sv
source/corePkg.sv
source/coreIfs.sv
source/instrSequencer.sv
source/registerFile.sv
source/executeUnit.sv
source/femtoCore.sv
bench/femtoCoreTb.sv
